//--- verilog/cps_ram_params.svh
//######################################
// Size constants for the shared CPU and
// video memory block. Include this file
// in any source that needs the widths.
//######################################

`ifndef CPS_RAM_PARAMS_SVH
`define CPS_RAM_PARAMS_SVH

// Word offset inside one 32K-word bank
`define CPS_RAM_OFS_W   15

// Bank field above the offset
`define CPS_RAM_BANK_W  2

`define CPS_RAM_DW      16

// Only banks 0 to 2 hold video RAM
`define CPS_RAM_BANKS   3

`define CPS_RAM_FILL    {`CPS_RAM_DW{1'b1}}

`endif

//--- verilog/cps_ram_pkg.sv
//######################################
// Shared types for the memory block.
// Referenced with scoped names, as in
// cps_ram_pkg::word_t.
//######################################

`include "cps_ram_params.svh"

package cps_ram_pkg;

    // Bank in the upper bits, word offset below
    typedef struct packed {
        logic [`CPS_RAM_BANK_W-1:0] bank;
        logic [`CPS_RAM_OFS_W-1:0]  ofs;
    } cpu_addr_s;

    // The 17-bit word address, raw or split
    typedef union packed {
        logic [`CPS_RAM_BANK_W+`CPS_RAM_OFS_W-1:0] flat;
        cpu_addr_s                                 field;
    } cpu_addr_u;

    typedef logic [`CPS_RAM_DW-1:0] word_t;

    // Active-high lane enables, bit 1 is the upper byte
    typedef logic [1:0] byte_mask_t;

endpackage

//--- verilog/mem_access_if.sv
//######################################
// CPU-side access bus between the bus
// controller and one memory. The ctrl
// end drives the request, mem returns
// registered read data.
//######################################

interface mem_access_if;

    cps_ram_pkg::cpu_addr_u  addr;
    cps_ram_pkg::word_t      wdata;
    cps_ram_pkg::byte_mask_t be;
    // Single-cycle write pulse
    logic                    we;
    cps_ram_pkg::word_t      rdata;

    modport ctrl (
        output addr,
        output wdata,
        output be,
        output we,
        input  rdata
    );

    modport mem (
        input  addr,
        input  wdata,
        input  be,
        input  we,
        output rdata
    );

endinterface

//--- verilog/work_ram.sv
//######################################
// CPU work RAM, 32K words on clk_cpu.
// Byte lanes are written separately and
// the read word is registered each cycle.
//######################################

`include "cps_ram_params.svh"

module work_ram (
    input logic        clk_cpu,
    mem_access_if.mem  bus
);

    localparam int DEPTH = 1 << `CPS_RAM_OFS_W;

    // Two byte lanes per word
    logic [1:0][7:0] mem [0:DEPTH-1];

    // Bank bits are ignored, the RAM is decoded by its own select
    always_ff @(posedge clk_cpu) begin
        for (int l = 0; l < 2; l++) begin
            if (bus.we && bus.be[l]) begin
                mem[bus.addr.field.ofs][l] <= bus.wdata[l*8 +: 8];
            end
        end
        // Old content comes back during a write
        bus.rdata <= mem[bus.addr.field.ofs];
    end

endmodule

//--- verilog/vram_store.sv
//######################################
// Video RAM, three banks of 32K words.
// The CPU reads and byte-writes on
// clk_cpu, the graphics engine only
// reads, on clk_gfx.
//######################################

`include "cps_ram_params.svh"

module vram_store (
    input  logic                   clk_cpu,
    input  logic                   clk_gfx,
    input  cps_ram_pkg::cpu_addr_u gfx_addr,
    output cps_ram_pkg::word_t     gfx_rdata,
    mem_access_if.mem              cpu
);

    localparam int DEPTH = 1 << `CPS_RAM_OFS_W;
    localparam logic [`CPS_RAM_BANK_W-1:0] NBANKS = `CPS_RAM_BANK_W'(`CPS_RAM_BANKS);

    logic [1:0][7:0] mem [0:`CPS_RAM_BANKS-1][0:DEPTH-1];

    logic cpu_mapped;
    logic gfx_mapped;

    assign cpu_mapped = cpu.addr.field.bank < NBANKS;
    assign gfx_mapped = gfx_addr.field.bank < NBANKS;

    // CPU port
    always_ff @(posedge clk_cpu) begin
        if (cpu_mapped) begin
            for (int l = 0; l < 2; l++) begin
                if (cpu.we && cpu.be[l]) begin
                    mem[cpu.addr.field.bank][cpu.addr.field.ofs][l] <= cpu.wdata[l*8 +: 8];
                end
            end
            cpu.rdata <= mem[cpu.addr.field.bank][cpu.addr.field.ofs];
        end
    end

    // Graphics port, bank 3 reads as blank
    always_ff @(posedge clk_gfx) begin
        if (gfx_mapped) begin
            gfx_rdata <= mem[gfx_addr.field.bank][gfx_addr.field.ofs];
        end else begin
            gfx_rdata <= `CPS_RAM_FILL;
        end
    end

    // The controller must never strobe the unmapped bank
    a_no_bank3_write: assert property (
        @(posedge clk_cpu) cpu.we |-> cpu_mapped
    );

endmodule

//--- verilog/cpu_bus_ctrl.sv
//######################################
// CPU bus controller. Turns a select
// edge into one memory access and acks
// it two cycles later with main_ok.
// Ack is held until the select drops.
//######################################

`include "cps_ram_params.svh"

module cpu_bus_ctrl (
    input  logic                   rst,
    input  logic                   clk_cpu,
    input  logic                   main_ram_cs,
    input  logic                   main_vram_cs,
    input  logic                   main_rnw,
    input  logic [1:0]             dsn,
    input  cps_ram_pkg::cpu_addr_u main_addr,
    input  cps_ram_pkg::word_t     main_dout,
    output logic                   main_ok,
    output cps_ram_pkg::word_t     main_data,
    mem_access_if.ctrl             work,
    mem_access_if.ctrl             vram
);

    localparam logic [`CPS_RAM_BANK_W-1:0] NBANKS = `CPS_RAM_BANK_W'(`CPS_RAM_BANKS);

    logic cs_any;
    logic main_last;
    logic main_edge;
    logic wr_req;
    logic sel_work;
    logic sel_vram;
    logic work_we;
    logic vram_we;
    logic [1:0] ok_sh;

    cps_ram_pkg::cpu_addr_u  lat_addr;
    cps_ram_pkg::word_t      lat_data;
    cps_ram_pkg::byte_mask_t lat_be;
    cps_ram_pkg::word_t      read_word;

    assign cs_any    = main_ram_cs | main_vram_cs;
    // Only a fresh select starts an access
    assign main_edge = cs_any & ~main_last;
    assign wr_req    = main_edge & ~main_rnw;

    // Request payload
    always_ff @(posedge clk_cpu) begin
        if (main_edge) begin
            lat_addr <= main_addr;
            lat_data <= main_dout;
            lat_be   <= ~dsn;
        end
    end

    // Both buses see the same request and the strobes pick the target
    assign work.addr  = lat_addr;
    assign work.wdata = lat_data;
    assign work.be    = lat_be;
    assign work.we    = work_we;

    assign vram.addr  = lat_addr;
    assign vram.wdata = lat_data;
    assign vram.be    = lat_be;
    assign vram.we    = vram_we;

    // Read data source for the latched target
    always_comb begin
        if (sel_work) begin
            read_word = work.rdata;
        end else if (sel_vram && lat_addr.field.bank < NBANKS) begin
            read_word = vram.rdata;
        end else begin
            read_word = `CPS_RAM_FILL;
        end
    end

    always_ff @(posedge clk_cpu, posedge rst) begin
        if (rst) begin
            main_last <= 1'b0;
            sel_work  <= 1'b0;
            sel_vram  <= 1'b0;
            work_we   <= 1'b0;
            vram_we   <= 1'b0;
            ok_sh     <= 2'b00;
            main_ok   <= 1'b0;
            main_data <= `CPS_RAM_FILL;
        end else begin
            main_last <= cs_any;
            // Memory sees the strobe one edge after the request
            work_we   <= wr_req & main_ram_cs;
            vram_we   <= wr_req & main_vram_cs & (main_addr.field.bank < NBANKS);
            ok_sh     <= {main_edge, ok_sh[1]};
            if (main_edge) begin
                sel_work <= main_ram_cs;
                sel_vram <= main_vram_cs;
            end
            if (ok_sh[0]) begin
                main_ok   <= 1'b1;
                main_data <= read_word;
            end
            // Four-phase release
            if (!cs_any) begin
                main_ok <= 1'b0;
            end
        end
    end

    a_one_select: assert property (
        @(posedge clk_cpu) disable iff (rst) !(main_ram_cs && main_vram_cs)
    );

    // Ack only answers a select held since its request
    a_ok_needs_cs: assert property (
        @(posedge clk_cpu) disable iff (rst)
            $rose(main_ok) |-> $past(cs_any, 2) && $past(cs_any, 3)
    );

endmodule

//--- verilog/dma_read_port.sv
//######################################
// Graphics DMA read port on clk_gfx.
// The select is a level. Any change of
// address while it is high starts a new
// read and drops dma_ok until done.
//######################################

`include "cps_ram_params.svh"

module dma_read_port (
    input  logic                   rst,
    input  logic                   clk_gfx,
    input  logic                   vram_dma_cs,
    input  cps_ram_pkg::cpu_addr_u vram_dma_addr,
    input  cps_ram_pkg::word_t     gfx_rdata,
    output cps_ram_pkg::cpu_addr_u gfx_addr,
    output logic                   dma_ok,
    output cps_ram_pkg::word_t     dma_data
);

    logic       addr_valid;
    logic       addr_change;
    logic [1:0] rd_sh;

    // First access after reset always counts as a change
    assign addr_change = vram_dma_cs &
                         (~addr_valid | (vram_dma_addr.flat != gfx_addr.flat));

    // Latched scan address with the bank bits passed on as is
    always_ff @(posedge clk_gfx) begin
        if (vram_dma_cs) begin
            gfx_addr <= vram_dma_addr;
        end
    end

    always_ff @(posedge clk_gfx, posedge rst) begin
        if (rst) begin
            addr_valid <= 1'b0;
            rd_sh      <= 2'b00;
            dma_ok     <= 1'b0;
            dma_data   <= `CPS_RAM_FILL;
        end else begin
            if (vram_dma_cs) begin
                addr_valid <= 1'b1;
            end
            // A change restarts the two-cycle count
            if (addr_change) begin
                rd_sh <= 2'b10;
            end else begin
                rd_sh <= {1'b0, rd_sh[1]};
            end
            if (rd_sh[0]) begin
                dma_ok   <= 1'b1;
                dma_data <= gfx_rdata;
            end
            if (addr_change) begin
                dma_ok <= 1'b0;
            end
        end
    end

    // Address moved under a held select
    a_ok_drops: assert property (
        @(posedge clk_gfx) disable iff (rst)
            vram_dma_cs && $past(vram_dma_cs) &&
            (vram_dma_addr.flat != $past(vram_dma_addr.flat)) |=> !dma_ok
    );

endmodule

//--- verilog/cps_ram.sv
//######################################
// Memory block top level: work RAM and
// three video banks shared between the
// CPU bus and the graphics DMA engine.
//######################################

`include "cps_ram_params.svh"

module cps_ram (
    input  logic                                      rst,
    input  logic                                      clk_cpu,
    input  logic                                      clk_gfx,
    // CPU request
    input  logic                                      main_ram_cs,
    input  logic                                      main_vram_cs,
    input  logic                                      main_rnw,
    input  logic [1:0]                                dsn,
    input  logic [`CPS_RAM_BANK_W+`CPS_RAM_OFS_W-1:0] main_addr,
    input  logic [`CPS_RAM_DW-1:0]                    main_dout,
    // CPU response
    output logic                                      main_ok,
    output logic [`CPS_RAM_DW-1:0]                    main_data,
    // DMA request
    input  logic                                      vram_dma_cs,
    input  logic [`CPS_RAM_BANK_W+`CPS_RAM_OFS_W-1:0] vram_dma_addr,
    // DMA response
    output logic                                      dma_ok,
    output logic [`CPS_RAM_DW-1:0]                    dma_data
);

    cps_ram_pkg::cpu_addr_u gfx_addr;
    cps_ram_pkg::word_t     gfx_rdata;

    mem_access_if work_bus ();
    mem_access_if vram_bus ();

    cpu_bus_ctrl u_ctrl (
        .rst          (rst),
        .clk_cpu      (clk_cpu),
        .main_ram_cs  (main_ram_cs),
        .main_vram_cs (main_vram_cs),
        .main_rnw     (main_rnw),
        .dsn          (dsn),
        .main_addr    (main_addr),
        .main_dout    (main_dout),
        .main_ok      (main_ok),
        .main_data    (main_data),
        .work         (work_bus.ctrl),
        .vram         (vram_bus.ctrl)
    );

    work_ram u_work (
        .clk_cpu (clk_cpu),
        .bus     (work_bus.mem)
    );

    vram_store u_vram (
        .clk_cpu   (clk_cpu),
        .clk_gfx   (clk_gfx),
        .gfx_addr  (gfx_addr),
        .gfx_rdata (gfx_rdata),
        .cpu       (vram_bus.mem)
    );

    // Scanner side, clk_gfx domain
    dma_read_port u_dma (
        .rst           (rst),
        .clk_gfx       (clk_gfx),
        .vram_dma_cs   (vram_dma_cs),
        .vram_dma_addr (vram_dma_addr),
        .gfx_rdata     (gfx_rdata),
        .gfx_addr      (gfx_addr),
        .dma_ok        (dma_ok),
        .dma_data      (dma_data)
    );

endmodule

//--- bench/cps_ram_tb.sv
//######################################
// Testbench for the memory block. Runs
// the vector file through the CPU and
// DMA ports and checks the read data.
//######################################

`include "cps_ram_params.svh"

module cps_ram_tb;

    localparam int MAX_VEC = 64;
    localparam int LIMIT   = 20;

    logic        rst;
    logic        clk_cpu;
    logic        clk_gfx;
    logic        main_ram_cs;
    logic        main_vram_cs;
    logic        main_rnw;
    logic [1:0]  dsn;
    logic [16:0] main_addr;
    logic [15:0] main_dout;
    logic        main_ok;
    logic [15:0] main_data;
    logic        vram_dma_cs;
    logic [16:0] vram_dma_addr;
    logic        dma_ok;
    logic [15:0] dma_data;

    // Six fields per vector
    logic [19:0] vec_mem [0:6*MAX_VEC-1];
    logic [3:0]  v_op;
    logic        v_tgt;
    logic [16:0] v_addr;
    logic [15:0] v_data;
    logic [1:0]  v_dsn;
    logic [15:0] v_exp;

    int pass_cnt;
    int fail_cnt;
    int pass_mark;
    int fail_mark;
    bit timed_out;

    cps_ram cps_ram_i (.*);

    initial begin
        clk_cpu = 1'b0;
        forever #50 clk_cpu = ~clk_cpu;
    end

    initial begin
        clk_gfx = 1'b0;
        forever #25 clk_gfx = ~clk_gfx;
    end

    task automatic report_mismatch(input string what, input logic [15:0] exp,
                                   input logic [15:0] got);
        $display("** Error at time %0t: %s expected %h got %h", $time, what, exp, got);
        fail_cnt++;
    endtask

    task automatic report_timeout(input int idx, input string what);
        $display("Vector %0d timed out waiting for %s", idx, what);
        fail_cnt++;
        timed_out = 1'b1;
    endtask

    task automatic end_group(input int grp);
        $display("Group %0d done: %0d checks passed, %0d failed", grp,
                 pass_cnt - pass_mark, fail_cnt - fail_mark);
        pass_mark = pass_cnt;
        fail_mark = fail_cnt;
    endtask

    // One four-phase CPU access with an optional hold after the ack
    task automatic cpu_access(input int idx, input int hold);
        int n;
        logic [15:0] got;
        @(posedge clk_cpu);
        main_ram_cs  <= ~v_tgt;
        main_vram_cs <= v_tgt;
        main_rnw     <= (v_op != 4'h0);
        dsn          <= v_dsn;
        main_addr    <= v_addr;
        main_dout    <= v_data;
        n = 0;
        do begin
            @(negedge clk_cpu);
            n++;
        end while (!main_ok && n < LIMIT);
        if (!main_ok) begin
            report_timeout(idx, "main_ok to rise");
        end else begin
            got = main_data;
            if (v_op != 4'h0 && got !== v_exp) begin
                report_mismatch($sformatf("vector %0d", idx), v_exp, got);
            end else if (v_op != 4'h0) begin
                pass_cnt++;
            end
            for (int c = 0; c < hold; c++) begin
                @(negedge clk_cpu);
                if (!main_ok) begin
                    $display("Vector %0d: main_ok dropped while select was held", idx);
                    fail_cnt++;
                end else if (main_data !== v_exp) begin
                    report_mismatch($sformatf("vector %0d hold", idx), v_exp, main_data);
                end else begin
                    pass_cnt++;
                end
            end
            @(posedge clk_cpu);
            main_ram_cs  <= 1'b0;
            main_vram_cs <= 1'b0;
            n = 0;
            do begin
                @(negedge clk_cpu);
                n++;
            end while (main_ok && n < LIMIT);
            if (main_ok) begin
                report_timeout(idx, "main_ok to fall");
            end
        end
    endtask

    // Scanner keeps its select high while the address moves
    task automatic dma_access(input int idx);
        int n;
        bit same;
        same = vram_dma_cs && (vram_dma_addr == v_addr);
        @(posedge clk_gfx);
        vram_dma_cs   <= 1'b1;
        vram_dma_addr <= v_addr;
        if (same) begin
            repeat (4) begin
                @(negedge clk_gfx);
                if (!dma_ok) begin
                    $display("Vector %0d: dma_ok dropped on an unchanged address", idx);
                    fail_cnt++;
                end
            end
        end else begin
            n = 0;
            do begin
                @(negedge clk_gfx);
                n++;
            end while (dma_ok && n < LIMIT);
            if (dma_ok) begin
                report_timeout(idx, "dma_ok to fall");
            end
            n = 0;
            while (!dma_ok && n < LIMIT) begin
                @(negedge clk_gfx);
                n++;
            end
            if (!dma_ok) begin
                report_timeout(idx, "dma_ok to rise");
            end
        end
        if (!timed_out && dma_data !== v_exp) begin
            report_mismatch($sformatf("vector %0d", idx), v_exp, dma_data);
        end else if (!timed_out) begin
            pass_cnt++;
        end
    endtask

    initial begin
        int i;
        rst           <= 1'b1;
        main_ram_cs   <= 1'b0;
        main_vram_cs  <= 1'b0;
        main_rnw      <= 1'b1;
        dsn           <= 2'b00;
        main_addr     <= '0;
        main_dout     <= '0;
        vram_dma_cs   <= 1'b0;
        vram_dma_addr <= '0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        pass_mark = 0;
        fail_mark = 0;
        timed_out = 1'b0;
        $readmemh("bench/cps_ram_vectors.txt", vec_mem);
        repeat (10) @(posedge clk_cpu);
        rst <= 1'b0;
        @(negedge clk_cpu);
        // Idle state straight out of reset
        if (main_ok || dma_ok) begin
            $display("main_ok or dma_ok is high after reset");
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
        if (main_data !== `CPS_RAM_FILL) begin
            report_mismatch("main_data after reset", `CPS_RAM_FILL, main_data);
        end else begin
            pass_cnt++;
        end
        if (dma_data !== `CPS_RAM_FILL) begin
            report_mismatch("dma_data after reset", `CPS_RAM_FILL, dma_data);
        end else begin
            pass_cnt++;
        end
        end_group(0);
        i = 0;
        while (i < MAX_VEC && !timed_out) begin
            v_op   = vec_mem[6*i][3:0];
            v_tgt  = vec_mem[6*i+1][0];
            v_addr = vec_mem[6*i+2][16:0];
            v_data = vec_mem[6*i+3][15:0];
            v_dsn  = vec_mem[6*i+4][1:0];
            v_exp  = vec_mem[6*i+5][15:0];
            if (v_op == 4'hf) begin
                break;
            end
            case (v_op)
                4'h0, 4'h1: cpu_access(i, 0);
                4'h2:       dma_access(i);
                4'h3:       cpu_access(i, 5);
                4'he:       end_group(int'(v_addr));
                default: begin
                    $display("Vector %0d has unknown op %h", i, v_op);
                    fail_cnt++;
                end
            endcase
            i++;
        end
        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/cps_ram_pkg.sv
verilog/mem_access_if.sv
verilog/work_ram.sv
verilog/vram_store.sv
verilog/cpu_bus_ctrl.sv
verilog/dma_read_port.sv
verilog/cps_ram.sv
bench/cps_ram_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the memory block testbench with Verilator and run it.
# Exits non-zero when the log reports a failure.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f tb.f \
    --top-module cps_ram_tb \
    -o cps_ram_sim

./obj_dir/cps_ram_sim > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi

//--- bench/cps_ram_vectors.txt
// Columns, all hex: op target addr data dsn expected
// op 0 write, 1 read, 2 DMA read, 3 read held 5 cycles, e group end (addr = group), f end
0 0 00010 1234 0 0000
0 1 00010 a001 0 0000
0 1 08010 b002 0 0000
0 1 10010 c003 0 0000
1 0 00010 0000 0 1234
1 1 00010 0000 0 a001
1 1 08010 0000 0 b002
1 1 10010 0000 0 c003
0 0 07fff 55aa 0 0000
1 0 07fff 0000 0 55aa
e 0 00001 0000 0 0000
0 0 00010 99ee 1 0000
1 0 00010 0000 0 9934
0 1 08010 7766 2 0000
1 1 08010 0000 0 b066
0 1 10010 ffff 3 0000
1 1 10010 0000 0 c003
e 0 00002 0000 0 0000
3 0 00010 0000 0 9934
3 1 00010 0000 0 a001
e 0 00003 0000 0 0000
2 0 00010 0000 0 a001
2 0 00010 0000 0 a001
2 0 08010 0000 0 b066
2 0 10010 0000 0 c003
0 1 00020 4321 0 0000
2 0 00020 0000 0 4321
e 0 00004 0000 0 0000
0 1 18010 dead 0 0000
1 1 18010 0000 0 ffff
1 1 00010 0000 0 a001
1 1 08010 0000 0 b066
2 0 18010 0000 0 ffff
1 0 00010 0000 0 9934
e 0 00005 0000 0 0000
f 0 00000 0000 0 0000
